//--- Makefile
TOP := ecc_mem_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f ecc_mem_top.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "STATUS: PASS" sim.log

lint:
	verilator --lint-only --timing --assert -f ecc_mem_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- dv/ecc_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_tb;

    localparam int ADDR_W   = 6;
    localparam int DATA_W   = ecc_mem_pkg::DATA_W;
    localparam int NROWS    = 9;
    localparam int RD_LIMIT = 20;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [1:0]        nflip;
        logic [6:0]        pos_a;
        logic [6:0]        pos_b;
        logic              bypass;
        logic              scrub;
        logic              reread;
        logic              exp_sbit;
        logic              exp_dbit;
    } row_t;

    logic                   clk;
    logic                   rst_n;
    logic                   mem_req;
    logic                   mem_we;
    logic [ADDR_W-1:0]      mem_addr;
    logic [DATA_W-1:0]      mem_wdata;
    logic                   mem_rvalid;
    logic [DATA_W-1:0]      mem_rdata;
    logic                   mem_sbit_err;
    logic                   mem_dbit_err;
    logic                   csr_we;
    ecc_mem_pkg::csr_addr_e csr_addr;
    logic [31:0]            csr_wdata;
    logic [31:0]            csr_rdata;

    row_t rows [NROWS];

    ecc_mem_top #(.ADDR_WIDTH(ADDR_W)) ecc_mem_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // Tasks start and end on a falling edge.
    task automatic csr_write(input ecc_mem_pkg::csr_addr_e addr, input logic [31:0] data);
        csr_we    = 1'b1;
        csr_addr  = addr;
        csr_wdata = data;
        @(negedge clk);
        csr_we = 1'b0;
    endtask

    task automatic csr_read(input ecc_mem_pkg::csr_addr_e addr, output logic [31:0] data);
        csr_addr = addr;
        @(negedge clk);
        data = csr_rdata;
    endtask

    task automatic mem_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        mem_req   = 1'b1;
        mem_we    = 1'b1;
        mem_addr  = addr;
        mem_wdata = data;
        @(negedge clk);
        mem_req = 1'b0;
        mem_we  = 1'b0;
    endtask

    task automatic read_check(input int row, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] exp_data,
                              input logic exp_s, input logic exp_d);
        int                lat;
        logic [DATA_W-1:0] got;
        logic              got_s;
        logic              got_d;
        mem_req  = 1'b1;
        mem_we   = 1'b0;
        mem_addr = addr;
        @(negedge clk);
        mem_req = 1'b0;
        lat = 1;
        while (!mem_rvalid && lat < RD_LIMIT) begin
            @(negedge clk);
            lat++;
        end
        assert (mem_rvalid)
        else stop_on_error($sformatf("No read response arrived for address %0d.", addr));
        got   = mem_rdata;
        got_s = mem_sbit_err;
        got_d = mem_dbit_err;
        // Controller is back in IDLE here.
        @(negedge clk);
        assert (lat == 2)
        else stop_on_error($sformatf("ERR @%0t: row %0d rvalid after %0d cycles, expected 2",
                                     $time, row, lat));
        assert (got == exp_data)
        else stop_on_error($sformatf("ERR @%0t: row %0d rdata %h, expected %h",
                                     $time, row, got, exp_data));
        assert (got_s == exp_s && got_d == exp_d)
        else stop_on_error($sformatf("ERR @%0t: row %0d flags s=%0b d=%0b, expected s=%0b d=%0b",
                                     $time, row, got_s, got_d, exp_s, exp_d));
        assert (!mem_rvalid && !mem_sbit_err && !mem_dbit_err)
        else stop_on_error($sformatf("ERR @%0t: row %0d response strobes high after response",
                                     $time, row));
    endtask

    function automatic logic [DATA_W-1:0] random_word();
        logic [95:0] rnd;
        rnd = {$urandom(), $urandom(), $urandom()};
        return rnd[DATA_W-1:0];
    endfunction

    // Only flips that land in the data field show up in the read data.
    function automatic logic [DATA_W-1:0] apply_flips(input logic [DATA_W-1:0] d,
                                                      input logic [1:0] nflip,
                                                      input logic [6:0] pa,
                                                      input logic [6:0] pb);
        logic [DATA_W-1:0] r;
        r = d;
        if (nflip != 2'd0 && int'(pa) < DATA_W) begin
            r[pa] = ~r[pa];
        end
        if (nflip == 2'd2 && int'(pb) < DATA_W) begin
            r[pb] = ~r[pb];
        end
        return r;
    endfunction

    task automatic load_table();
        // addr, flips, pos a, pos b, bypass, scrub, re-read, sbit, dbit
        rows[0] = '{6'd1,  2'd0, 7'd0,  7'd0,  1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
        rows[1] = '{6'd2,  2'd1, 7'd5,  7'd0,  1'b0, 1'b1, 1'b1, 1'b1, 1'b0};
        rows[2] = '{6'd3,  2'd1, 7'd72, 7'd0,  1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
        rows[3] = '{6'd4,  2'd2, 7'd10, 7'd40, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
        rows[4] = '{6'd5,  2'd2, 7'd0,  7'd70, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};
        rows[5] = '{6'd6,  2'd1, 7'd20, 7'd0,  1'b1, 1'b0, 1'b1, 1'b0, 1'b0};
        rows[6] = '{6'd7,  2'd1, 7'd74, 7'd0,  1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
        rows[7] = '{6'd8,  2'd0, 7'd0,  7'd0,  1'b0, 1'b1, 1'b1, 1'b0, 1'b0};
        rows[8] = '{6'd63, 2'd1, 7'd68, 7'd0,  1'b0, 1'b1, 1'b1, 1'b1, 1'b0};
    endtask

    initial begin
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] exp_data;
        logic [31:0]       sb0;
        logic [31:0]       db0;
        logic [31:0]       val;
        logic              s2;
        logic              d2;
        int                sinc;
        int                dinc;
        void'($urandom(32'h351d8263));
        rst_n     = 1'b0;
        mem_req   = 1'b0;
        mem_we    = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        csr_we    = 1'b0;
        csr_addr  = ecc_mem_pkg::CSR_CTRL;
        csr_wdata = '0;
        load_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        for (int i = 0; i < NROWS; i++) begin
            csr_write(ecc_mem_pkg::CSR_CTRL, {30'd0, rows[i].scrub, rows[i].bypass});
            csr_write(ecc_mem_pkg::CSR_INJECT, {14'd0, rows[i].nflip, 1'b0, rows[i].pos_b,
                                                1'b0, rows[i].pos_a});
            csr_read(ecc_mem_pkg::CSR_SBIT_CNT, sb0);
            csr_read(ecc_mem_pkg::CSR_DBIT_CNT, db0);
            wdata = random_word();
            mem_write(rows[i].addr, wdata);
            // A single error is corrected unless bypass is on.
            if (rows[i].nflip == 2'd1 && !rows[i].bypass) begin
                exp_data = wdata;
            end else begin
                exp_data = apply_flips(wdata, rows[i].nflip, rows[i].pos_a, rows[i].pos_b);
            end
            read_check(i, rows[i].addr, exp_data, rows[i].exp_sbit, rows[i].exp_dbit);
            sinc = int'(rows[i].exp_sbit);
            dinc = int'(rows[i].exp_dbit);
            if (rows[i].reread) begin
                s2 = rows[i].exp_sbit && !rows[i].scrub;
                d2 = rows[i].exp_dbit;
                read_check(i, rows[i].addr, exp_data, s2, d2);
                sinc += int'(s2);
                dinc += int'(d2);
            end
            csr_read(ecc_mem_pkg::CSR_SBIT_CNT, val);
            assert (val == sb0 + 32'(sinc))
            else stop_on_error($sformatf("ERR @%0t: row %0d sbit count %0d, expected %0d",
                                         $time, i, val, sb0 + 32'(sinc)));
            csr_read(ecc_mem_pkg::CSR_DBIT_CNT, val);
            assert (val == db0 + 32'(dinc))
            else stop_on_error($sformatf("ERR @%0t: row %0d dbit count %0d, expected %0d",
                                         $time, i, val, db0 + 32'(dinc)));
            if (rows[i].exp_sbit || rows[i].exp_dbit) begin
                csr_read(ecc_mem_pkg::CSR_ERR_ADDR, val);
                assert (val == 32'(rows[i].addr))
                else stop_on_error($sformatf("ERR @%0t: row %0d err addr %0d, expected %0d",
                                             $time, i, val, rows[i].addr));
            end
        end

        // Injection applies to one write only.
        csr_write(ecc_mem_pkg::CSR_CTRL, 32'd0);
        csr_write(ecc_mem_pkg::CSR_INJECT, {14'd0, 2'd1, 8'd0, 1'b0, 7'd9});
        wdata = random_word();
        mem_write(6'd10, wdata);
        csr_read(ecc_mem_pkg::CSR_INJECT, val);
        assert (val[17:16] == 2'd0)
        else stop_on_error($sformatf("ERR @%0t: inject count %0d after write, expected 0",
                                     $time, val[17:16]));
        read_check(NROWS, 6'd10, wdata, 1'b1, 1'b0);
        wdata = random_word();
        mem_write(6'd11, wdata);
        read_check(NROWS, 6'd11, wdata, 1'b0, 1'b0);

        csr_write(ecc_mem_pkg::CSR_SBIT_CNT, 32'd1);
        csr_write(ecc_mem_pkg::CSR_DBIT_CNT, 32'd1);
        csr_read(ecc_mem_pkg::CSR_SBIT_CNT, sb0);
        csr_read(ecc_mem_pkg::CSR_DBIT_CNT, db0);
        assert (sb0 == 32'd0 && db0 == 32'd0)
        else stop_on_error($sformatf("ERR @%0t: counters %0d and %0d after clear, expected 0",
                                     $time, sb0, db0));

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- ecc_mem_top.f
rtl/ecc_mem_pkg.sv
rtl/ecc_69_cal.sv
rtl/ecc_mem_array.sv
rtl/ecc_mem_csr.sv
rtl/ecc_mem_ctrl.sv
rtl/ecc_mem_top.sv
dv/ecc_mem_tb.sv

//--- rtl/ecc_69_cal.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_69_cal (
    input  logic [ecc_mem_pkg::DATA_W-1:0] data_in,
    output logic [ecc_mem_pkg::DATA_W-1:0] data_out,
    input  logic [ecc_mem_pkg::PAR_W-1:0]  parity_in,
    output logic [ecc_mem_pkg::PAR_W-1:0]  parity_out,
    input  logic                           bypass,
    output logic [ecc_mem_pkg::DATA_W-1:0] mask,
    output logic                           sbit_err,
    output logic                           dbit_err
);

    localparam int DATA_W = ecc_mem_pkg::DATA_W;
    localparam int PAR_W  = ecc_mem_pkg::PAR_W;

    // Syndrome of each data bit. All columns have odd weight.
    localparam logic [PAR_W-1:0] H_COL [DATA_W] = '{
        8'h83, 8'h85, 8'h86, 8'h07,
        8'h89, 8'h8a, 8'h0b, 8'h8c,
        8'h0d, 8'h0e, 8'h8f, 8'h91,
        8'h92, 8'h13, 8'h94, 8'h15,
        8'h16, 8'h97, 8'h98, 8'h19,
        8'h1a, 8'h9b, 8'h1c, 8'h9d,
        8'h9e, 8'h1f, 8'ha1, 8'ha2,
        8'h23, 8'ha4, 8'h25, 8'h26,
        8'ha7, 8'ha8, 8'h29, 8'h2a,
        8'hab, 8'h2c, 8'had, 8'hae,
        8'h2f, 8'hb0, 8'h31, 8'h32,
        8'hb3, 8'h34, 8'hb5, 8'hb6,
        8'h37, 8'h38, 8'hb9, 8'hba,
        8'h3b, 8'hbc, 8'h3d, 8'h3e,
        8'hbf, 8'hc1, 8'hc2, 8'h43,
        8'hc4, 8'h45, 8'h46, 8'hc7,
        8'hc8, 8'h49, 8'h4a, 8'hcb,
        8'h4c
    };

    logic [PAR_W-1:0] syndrome;
    logic             single;

    // Check bits are the XOR of the columns of all set data bits.
    always_comb begin
        parity_out = '0;
        for (int i = 0; i < DATA_W; i++) begin
            if (data_in[i]) begin
                parity_out = parity_out ^ H_COL[i];
            end
        end
    end

    assign syndrome = parity_in ^ parity_out;

    always_comb begin
        for (int i = 0; i < DATA_W; i++) begin
            mask[i] = (syndrome == H_COL[i]);
        end
    end

    // A flipped check bit shows up as a one-hot syndrome.
    assign single = (|mask) || $onehot(syndrome);

    // Even-weight nonzero syndromes never match a column.
    assign data_out = bypass ? data_in : data_in ^ mask;
    assign sbit_err = !bypass && single;
    assign dbit_err = !bypass && !single && (syndrome != '0);

    // Duplicate columns would make the correction ambiguous.
    always_comb begin
        assert ($onehot0(mask))
        else $error("ecc_69_cal: syndrome matches more than one data column");
    end

endmodule

`default_nettype wire

//--- rtl/ecc_mem_array.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_array #(
    parameter int ADDR_WIDTH = 6
) (
    input  logic                           clk,
    input  logic                           arr_we,
    input  logic [ADDR_WIDTH-1:0]          arr_addr,
    input  logic [ecc_mem_pkg::CODE_W-1:0] arr_wdata,
    output logic [ecc_mem_pkg::CODE_W-1:0] arr_rdata
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    // Raw codewords, injected faults included.
    logic [ecc_mem_pkg::CODE_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (arr_we) begin
            mem[arr_addr] <= arr_wdata;
        end
    end

    // Registered read port, old data on a same-address write.
    always_ff @(posedge clk) begin
        arr_rdata <= mem[arr_addr];
    end

endmodule

`default_nettype wire

//--- rtl/ecc_mem_csr.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_csr #(
    parameter int ADDR_WIDTH = 6
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      csr_we,
    input  ecc_mem_pkg::csr_addr_e    csr_addr,
    input  logic [31:0]               csr_wdata,
    output logic [31:0]               csr_rdata,
    output logic                      bypass,
    output logic                      scrub_en,
    output logic [1:0]                inj_count,
    output logic [6:0]                inj_pos_a,
    output logic [6:0]                inj_pos_b,
    input  logic                      wr_done,
    input  logic                      mem_sbit_err,
    input  logic                      mem_dbit_err,
    input  logic [ADDR_WIDTH-1:0]     err_addr
);

    localparam int CNT_W = ecc_mem_pkg::CNT_W;

    logic [CNT_W-1:0]      sbit_cnt;
    logic [CNT_W-1:0]      dbit_cnt;
    logic [ADDR_WIDTH-1:0] err_addr_q;

    function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] v);
        return (&v) ? v : v + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bypass   <= 1'b0;
            scrub_en <= 1'b0;
        end else if (csr_we && csr_addr == ecc_mem_pkg::CSR_CTRL) begin
            bypass   <= csr_wdata[0];
            scrub_en <= csr_wdata[1];
        end
    end

    // One-shot. A host write in the same cycle wins over the clear.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inj_count <= 2'd0;
            inj_pos_a <= 7'd0;
            inj_pos_b <= 7'd0;
        end else if (csr_we && csr_addr == ecc_mem_pkg::CSR_INJECT) begin
            inj_pos_a <= csr_wdata[6:0];
            inj_pos_b <= csr_wdata[14:8];
            inj_count <= csr_wdata[17:16];
        end else if (wr_done) begin
            inj_count <= 2'd0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sbit_cnt <= '0;
        end else if (csr_we && csr_addr == ecc_mem_pkg::CSR_SBIT_CNT) begin
            sbit_cnt <= '0;
        end else if (mem_sbit_err) begin
            sbit_cnt <= sat_inc(sbit_cnt);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dbit_cnt <= '0;
        end else if (csr_we && csr_addr == ecc_mem_pkg::CSR_DBIT_CNT) begin
            dbit_cnt <= '0;
        end else if (mem_dbit_err) begin
            dbit_cnt <= sat_inc(dbit_cnt);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_addr_q <= '0;
        end else if (mem_sbit_err || mem_dbit_err) begin
            err_addr_q <= err_addr;
        end
    end

    always_comb begin
        case (csr_addr)
            ecc_mem_pkg::CSR_CTRL:     csr_rdata = {30'd0, scrub_en, bypass};
            ecc_mem_pkg::CSR_INJECT:   csr_rdata = {14'd0, inj_count, 1'b0, inj_pos_b,
                                                    1'b0, inj_pos_a};
            ecc_mem_pkg::CSR_SBIT_CNT: csr_rdata = 32'(sbit_cnt);
            ecc_mem_pkg::CSR_DBIT_CNT: csr_rdata = 32'(dbit_cnt);
            ecc_mem_pkg::CSR_ERR_ADDR: csr_rdata = 32'(err_addr_q);
            default:                   csr_rdata = 32'd0;
        endcase
    end

    // Positions past the codeword would silently inject nothing.
    a_inject_pos: assert property (@(posedge clk) disable iff (!rst_n)
        (csr_we && csr_addr == ecc_mem_pkg::CSR_INJECT && csr_wdata[17:16] != 2'd0)
        |-> (int'(csr_wdata[6:0]) < ecc_mem_pkg::CODE_W)
            && (!csr_wdata[17] || int'(csr_wdata[14:8]) < ecc_mem_pkg::CODE_W));

endmodule

`default_nettype wire

//--- rtl/ecc_mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_ctrl #(
    parameter int ADDR_WIDTH = 6
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           mem_req,
    input  logic                           mem_we,
    input  logic [ADDR_WIDTH-1:0]          mem_addr,
    input  logic [ecc_mem_pkg::DATA_W-1:0] mem_wdata,
    output logic                           mem_rvalid,
    output logic [ecc_mem_pkg::DATA_W-1:0] mem_rdata,
    output logic                           mem_sbit_err,
    output logic                           mem_dbit_err,
    input  logic                           scrub_en,
    input  logic [1:0]                     inj_count,
    input  logic [6:0]                     inj_pos_a,
    input  logic [6:0]                     inj_pos_b,
    output logic                           wr_done,
    output logic [ADDR_WIDTH-1:0]          err_addr,
    output logic [ecc_mem_pkg::DATA_W-1:0] cal_data_in,
    output logic [ecc_mem_pkg::PAR_W-1:0]  cal_parity_in,
    input  logic [ecc_mem_pkg::DATA_W-1:0] cal_data_out,
    input  logic [ecc_mem_pkg::PAR_W-1:0]  cal_parity_out,
    input  logic                           cal_sbit_err,
    input  logic                           cal_dbit_err,
    output logic                           arr_we,
    output logic [ADDR_WIDTH-1:0]          arr_addr,
    output logic [ecc_mem_pkg::CODE_W-1:0] arr_wdata,
    input  logic [ecc_mem_pkg::CODE_W-1:0] arr_rdata
);

    localparam int DATA_W = ecc_mem_pkg::DATA_W;
    localparam int CODE_W = ecc_mem_pkg::CODE_W;

    typedef enum logic [1:0] {
        IDLE,
        CHECK,
        RESP
    } state_e;

    state_e              state;
    logic                wr_accept;
    logic                rd_accept;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [DATA_W-1:0]   rdata_q;
    logic [CODE_W-1:0]   inj_mask;

    assign wr_accept = (state == IDLE) && mem_req && mem_we;
    assign rd_accept = (state == IDLE) && mem_req && !mem_we;
    assign wr_done   = wr_accept;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    state <= rd_accept ? CHECK : IDLE;
                CHECK:   state <= RESP;
                default: state <= IDLE;
            endcase
        end
    end

    // Response strobes are high only in RESP.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_rvalid   <= 1'b0;
            mem_sbit_err <= 1'b0;
            mem_dbit_err <= 1'b0;
        end else begin
            mem_rvalid   <= (state == CHECK);
            mem_sbit_err <= (state == CHECK) && cal_sbit_err;
            mem_dbit_err <= (state == CHECK) && cal_dbit_err;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            addr_q <= mem_addr;
        end
        if (state == CHECK) begin
            rdata_q <= cal_data_out;
        end
    end

    assign mem_rdata = rdata_q;
    assign err_addr  = addr_q;

    // Encode in IDLE, decode in CHECK, re-encode for scrub in RESP.
    always_comb begin
        case (state)
            CHECK:   cal_data_in = arr_rdata[DATA_W-1:0];
            RESP:    cal_data_in = rdata_q;
            default: cal_data_in = mem_wdata;
        endcase
    end

    assign cal_parity_in = arr_rdata[CODE_W-1:DATA_W];

    // Flipping the same position twice cancels.
    always_comb begin
        inj_mask = '0;
        if (inj_count != 2'd0) begin
            inj_mask = inj_mask ^ (CODE_W'(1) << inj_pos_a);
        end
        if (inj_count[1]) begin
            inj_mask = inj_mask ^ (CODE_W'(1) << inj_pos_b);
        end
    end

    always_comb begin
        arr_addr  = (state == IDLE) ? mem_addr : addr_q;
        arr_wdata = {cal_parity_out, cal_data_in};
        arr_we    = 1'b0;
        if (wr_accept) begin
            arr_we    = 1'b1;
            arr_wdata = {cal_parity_out, cal_data_in} ^ inj_mask;
        end else if (state == RESP) begin
            arr_we = scrub_en && mem_sbit_err;
        end
    end

    a_req_idle: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |-> state == IDLE);

endmodule

`default_nettype wire

//--- rtl/ecc_mem_pkg.sv
`default_nettype none

package ecc_mem_pkg;

    // Codeword layout is data in the low bits and check bits on top.
    localparam int DATA_W = 69;
    localparam int PAR_W  = 8;
    localparam int CODE_W = DATA_W + PAR_W;

    // Saturating error counters.
    localparam int CNT_W = 16;

    // Register map. Unlisted codes read as zero.
    typedef enum logic [2:0] {
        CSR_CTRL     = 3'd0,
        CSR_INJECT   = 3'd1,
        CSR_SBIT_CNT = 3'd2,
        CSR_DBIT_CNT = 3'd3,
        CSR_ERR_ADDR = 3'd4
    } csr_addr_e;

endpackage

`default_nettype wire

//--- rtl/ecc_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_top #(
    parameter int ADDR_WIDTH = 6
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           mem_req,
    input  logic                           mem_we,
    input  logic [ADDR_WIDTH-1:0]          mem_addr,
    input  logic [ecc_mem_pkg::DATA_W-1:0] mem_wdata,
    output logic                           mem_rvalid,
    output logic [ecc_mem_pkg::DATA_W-1:0] mem_rdata,
    output logic                           mem_sbit_err,
    output logic                           mem_dbit_err,
    input  logic                           csr_we,
    input  ecc_mem_pkg::csr_addr_e         csr_addr,
    input  logic [31:0]                    csr_wdata,
    output logic [31:0]                    csr_rdata
);

    logic                           bypass;
    logic                           scrub_en;
    logic [1:0]                     inj_count;
    logic [6:0]                     inj_pos_a;
    logic [6:0]                     inj_pos_b;
    logic                           wr_done;
    logic [ADDR_WIDTH-1:0]          err_addr;
    logic [ecc_mem_pkg::DATA_W-1:0] cal_data_in;
    logic [ecc_mem_pkg::PAR_W-1:0]  cal_parity_in;
    logic [ecc_mem_pkg::DATA_W-1:0] cal_data_out;
    logic [ecc_mem_pkg::PAR_W-1:0]  cal_parity_out;
    logic                           cal_sbit_err;
    logic                           cal_dbit_err;
    logic                           arr_we;
    logic [ADDR_WIDTH-1:0]          arr_addr;
    logic [ecc_mem_pkg::CODE_W-1:0] arr_wdata;
    logic [ecc_mem_pkg::CODE_W-1:0] arr_rdata;

    ecc_mem_ctrl #(.ADDR_WIDTH(ADDR_WIDTH)) ecc_mem_ctrl_i (.*);

    ecc_mem_array #(.ADDR_WIDTH(ADDR_WIDTH)) ecc_mem_array_i (.*);

    ecc_mem_csr #(.ADDR_WIDTH(ADDR_WIDTH)) ecc_mem_csr_i (.*);

    // Correction mask is not needed outside the calculator.
    ecc_69_cal ecc_69_cal_i (
        .data_in    (cal_data_in),
        .data_out   (cal_data_out),
        .parity_in  (cal_parity_in),
        .parity_out (cal_parity_out),
        .bypass     (bypass),
        .mask       (),
        .sbit_err   (cal_sbit_err),
        .dbit_err   (cal_dbit_err)
    );

endmodule

`default_nettype wire
